// ==== tb.f ====
design/event_pkg.sv
design/sfr_map_pkg.sv
design/stat_chan_if.sv
design/sfr_decoder.sv
design/event_status_channel.sv
design/event_conditioner.sv
design/ctrl_regs.sv
design/sfr_readback.sv
design/regbank_top.sv
verification/regbank_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module regbank_tb -o regbank_sim; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/regbank_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
   exit 0
else
   echo "Pass message not found in simulator output"
   exit 1
fi

// ==== verification/regbank_tb.sv ====
`timescale 1ns/1ps

module regbank_tb
   import sfr_map_pkg::*;
   import event_pkg::*;
();

   localparam int TIMEOUT_CYC = 20;  // Debounce poll limit in cycles

   // Write, read check, event pulse, event with clearing write, input level,
   // idle, interrupt check, control output check, PROLVL poll
   typedef enum int {
      K_WR, K_RD, K_EVT, K_EVT_WR, K_LVL, K_IDLE, K_INTR, K_CTRL, K_WAIT
   } kind_t;

   typedef struct {
      kind_t     kind;
      int        tgt;   // Channel, control index or level input (0 p0, 1 srci)
      sfr_addr_t addr;
      sfr_data_t data;
      sfr_data_t exp;
   } step_t;

   logic              clk = 1'b0;
   logic              rrstz;
   logic              i_sfr_w;
   sfr_addr_t         i_sfr_addr;
   sfr_data_t         i_sfr_wdat;
   evt_vec_t          i_rx_evt;
   evt_vec_t          i_tx_evt;
   evt_vec_t          i_i2c_evt;
   sfr_data_t         i_p0;
   pro_vec_t          i_srci;
   sfr_data_t         o_sfr_rdat;
   logic [N_CHAN-1:0] o_intr;
   sfr_data_t         o_txctl;
   sfr_data_t         o_gpf;
   sfr_data_t         o_ccctl;
   sfr_data_t         o_cmp_opt;
   evt_vec_t          ext_evt [CH_I2C+1];  // External event inputs by channel
   step_t             steps [$];

   assign i_rx_evt  = ext_evt[CH_RX];
   assign i_tx_evt  = ext_evt[CH_TX];
   assign i_i2c_evt = ext_evt[CH_I2C];

   regbank_top regbank_top_i (.*);

   always #2 clk = ~clk;  // 4 ns period

   // ==================================================
   // Compare tasks
   // ==================================================
   task automatic stop_on_error();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_rdat(sfr_addr_t addr, sfr_data_t got, sfr_data_t exp);
      if (got !== exp) begin
         $display("MISMATCH o_sfr_rdat at address %h: got %h, expected %h", addr, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_intr(logic [N_CHAN-1:0] got, logic [N_CHAN-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH o_intr: got %h, expected %h", got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_ctrl(string name, sfr_data_t got, sfr_data_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   // ==================================================
   // Step execution, entered and left on a falling edge
   // ==================================================
   task automatic run_step(step_t s);
      case (s.kind)
         K_WR, K_EVT, K_EVT_WR: begin
            if (s.kind != K_WR)
               ext_evt[s.tgt] = s.data;
            i_sfr_w    = (s.kind != K_EVT);
            i_sfr_addr = s.addr;
            i_sfr_wdat = s.data;  // Event bits double as the clear mask
            @(negedge clk);
            ext_evt[s.tgt] = '0;
            i_sfr_w        = 1'b0;
         end
         K_LVL: begin
            if (s.tgt == 0)
               i_p0 = s.data;
            else
               i_srci = s.data[N_PRO-1:0];
            @(negedge clk);
         end
         K_IDLE: repeat (s.data) @(negedge clk);
         K_RD, K_INTR, K_CTRL: begin
            i_sfr_addr = s.addr;
            #1;  // Let the read mux settle
            if (s.kind == K_RD)
               check_rdat(s.addr, o_sfr_rdat, s.exp);
            else if (s.kind == K_INTR)
               check_intr(o_intr, s.exp[N_CHAN-1:0]);
            else begin
               case (s.tgt)
                  CTRL_TXCTL: check_ctrl("o_txctl", o_txctl, s.exp);
                  CTRL_GPF:   check_ctrl("o_gpf", o_gpf, s.exp);
                  CTRL_CCCTL: check_ctrl("o_ccctl", o_ccctl, s.exp);
                  default:    check_ctrl("o_cmp_opt", o_cmp_opt, s.exp);
               endcase
            end
            @(negedge clk);
         end
         default: begin
            i_sfr_addr = ADDR_PROLVL;
            #1;
            for (int cyc = 0; o_sfr_rdat !== s.exp; cyc++) begin
               if (cyc == TIMEOUT_CYC) begin
                  $display("Wait for PROLVL %h expired after %0d cycles", s.exp, cyc);
                  stop_on_error();
               end
               @(negedge clk);
               #1;
            end
            @(negedge clk);
         end
      endcase
   endtask

   // ==================================================
   // Stimulus table
   // ==================================================
   task automatic add_step(kind_t kind, int tgt, sfr_addr_t addr, sfr_data_t data,
                           sfr_data_t exp);
      step_t s;
      s = '{kind, tgt, addr, data, exp};
      steps.push_back(s);
   endtask

   task automatic build_table();
      sfr_addr_t ctrl_addr [N_CTRL];
      sfr_data_t ctrl_rst [N_CTRL];
      sfr_data_t ctrl_val [N_CTRL];
      sfr_data_t bit_v;
      ctrl_addr = '{ADDR_TXCTL, ADDR_GPF, ADDR_CCCTL, ADDR_CMPOPT};  // Strobe bit order
      ctrl_rst  = '{RST_TXCTL, RST_GPF, RST_CCCTL, RST_CMPOPT};
      for (int r = 0; r < N_CTRL; r++) begin  // After reset
         add_step(K_CTRL, r, '0, '0, ctrl_rst[r]);
         add_step(K_RD, 0, ctrl_addr[r], '0, ctrl_rst[r]);
      end
      for (int c = 0; c < N_CHAN; c++) begin
         add_step(K_RD, 0, STA_ADDR[c], '0, 8'h00);
         add_step(K_RD, 0, MSK_ADDR[c], '0, 8'h00);
      end
      add_step(K_RD, 0, ADDR_PROLVL, '0, 8'h00);
      add_step(K_RD, 0, 8'h00, '0, 8'hFF);  // Unmapped
      add_step(K_INTR, 0, '0, '0, 8'h00);
      for (int r = 0; r < N_CTRL; r++) begin  // Random control bytes
         ctrl_val[r] = sfr_data_t'($urandom);
         add_step(K_WR, 0, ctrl_addr[r], ctrl_val[r], '0);
         add_step(K_CTRL, r, '0, '0, ctrl_val[r]);
         add_step(K_RD, 0, ctrl_addr[r], '0, ctrl_val[r]);
      end
      for (int r = 0; r < N_CTRL; r++) begin  // Each byte kept after later writes
         add_step(K_CTRL, r, '0, '0, ctrl_val[r]);
         add_step(K_RD, 0, ctrl_addr[r], '0, ctrl_val[r]);
      end
      for (int c = CH_RX; c <= CH_I2C; c++) begin  // Set, mask, clear
         bit_v = 8'h02 << c;
         add_step(K_EVT, c, '0, bit_v, '0);
         add_step(K_RD, 0, STA_ADDR[c], '0, bit_v);
         add_step(K_INTR, 0, '0, '0, 8'h00);
         add_step(K_WR, 0, MSK_ADDR[c], bit_v, '0);
         add_step(K_INTR, 0, '0, '0, 8'h01 << c);
         add_step(K_WR, 0, STA_ADDR[c], bit_v, '0);
         add_step(K_RD, 0, STA_ADDR[c], '0, 8'h00);
         add_step(K_INTR, 0, '0, '0, 8'h00);
      end
      add_step(K_EVT, CH_TX, '0, 8'h80, '0);
      add_step(K_EVT_WR, CH_TX, STA_ADDR[CH_TX], 8'h80, '0);  // Set beats clear
      add_step(K_RD, 0, STA_ADDR[CH_TX], '0, 8'h80);
      add_step(K_WR, 0, STA_ADDR[CH_TX], 8'h80, '0);
      add_step(K_RD, 0, STA_ADDR[CH_TX], '0, 8'h00);
      add_step(K_LVL, 0, '0, 8'h5A, '0);  // Port-0 toggles
      add_step(K_RD, 0, STA_ADDR[CH_P0], '0, 8'h5A);
      add_step(K_INTR, 0, '0, '0, 8'h00);
      add_step(K_WR, 0, MSK_ADDR[CH_P0], 8'h02, '0);
      add_step(K_INTR, 0, '0, '0, 8'h08);
      add_step(K_WR, 0, STA_ADDR[CH_P0], 8'hFF, '0);
      add_step(K_INTR, 0, '0, '0, 8'h00);
      add_step(K_LVL, 0, '0, 8'h18, '0);
      add_step(K_RD, 0, STA_ADDR[CH_P0], '0, 8'h5A ^ 8'h18);
      add_step(K_WR, 0, STA_ADDR[CH_P0], 8'hFF, '0);
      add_step(K_LVL, 1, '0, 8'h01, '0);  // One-cycle glitch
      add_step(K_LVL, 1, '0, 8'h00, '0);
      add_step(K_IDLE, 0, '0, 8'd10, '0);
      add_step(K_RD, 0, ADDR_PROLVL, '0, 8'h00);
      add_step(K_RD, 0, STA_ADDR[CH_PRO], '0, 8'h00);
      add_step(K_LVL, 1, '0, 8'h04, '0);  // Stable rise on bit 2
      add_step(K_WAIT, 0, '0, '0, 8'h04);
      add_step(K_RD, 0, STA_ADDR[CH_PRO], '0, 8'h04);
      add_step(K_WR, 0, MSK_ADDR[CH_PRO], 8'h04, '0);
      add_step(K_INTR, 0, '0, '0, 8'h10);
      add_step(K_WR, 0, STA_ADDR[CH_PRO], 8'h04, '0);
      add_step(K_INTR, 0, '0, '0, 8'h00);
   endtask

   initial begin
      rrstz      = 1'b0;
      i_sfr_w    = 1'b0;
      i_sfr_addr = '0;
      i_sfr_wdat = '0;
      ext_evt    = '{default: '0};
      i_p0       = '0;
      i_srci     = '0;
      void'($urandom(11692));
      build_table();
      repeat (10) @(negedge clk);
      rrstz = 1'b1;
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== design/regbank_top.sv ====
`timescale 1ns/1ps

module regbank_top
   import sfr_map_pkg::*;
   import event_pkg::*;
(
   input  logic              clk,
   input  logic              rrstz,
   input  logic              i_sfr_w,
   input  sfr_addr_t         i_sfr_addr,
   input  sfr_data_t         i_sfr_wdat,
   input  evt_vec_t          i_rx_evt,
   input  evt_vec_t          i_tx_evt,
   input  evt_vec_t          i_i2c_evt,
   input  sfr_data_t         i_p0,
   input  pro_vec_t          i_srci,
   output sfr_data_t         o_sfr_rdat,
   output logic [N_CHAN-1:0] o_intr,
   output sfr_data_t         o_txctl,
   output sfr_data_t         o_gpf,
   output sfr_data_t         o_ccctl,
   output sfr_data_t         o_cmp_opt
);

   ctrl_we_t  ctrl_we;
   sfr_data_t wdat;
   evt_vec_t  p0_chg;
   pro_vec_t  pro_lvl;
   pro_vec_t  pro_chg;
   evt_vec_t  chan_evt [N_CHAN];

   stat_chan_if chan_if [N_CHAN] ();

   // ==================================================
   // Write side
   // ==================================================
   sfr_decoder u_dec (
      .i_sfr_w    (i_sfr_w),
      .i_sfr_addr (i_sfr_addr),
      .i_sfr_wdat (i_sfr_wdat),
      .o_ctrl_we  (ctrl_we),
      .o_wdat     (wdat),
      .chan_if    (chan_if)
   );

   ctrl_regs u_ctrl (
      .clk       (clk),
      .rrstz     (rrstz),
      .i_we      (ctrl_we),
      .i_wdat    (wdat),
      .o_txctl   (o_txctl),
      .o_gpf     (o_gpf),
      .o_ccctl   (o_ccctl),
      .o_cmp_opt (o_cmp_opt)
   );

   event_conditioner u_cond (
      .clk       (clk),
      .rrstz     (rrstz),
      .i_p0      (i_p0),
      .i_srci    (i_srci),
      .o_p0_chg  (p0_chg),
      .o_pro_lvl (pro_lvl),
      .o_pro_chg (pro_chg)
   );

   // Event sources in channel order
   assign chan_evt[CH_RX]  = i_rx_evt;
   assign chan_evt[CH_TX]  = i_tx_evt;
   assign chan_evt[CH_I2C] = i_i2c_evt;
   assign chan_evt[CH_P0]  = p0_chg;
   assign chan_evt[CH_PRO] = {{($bits(evt_vec_t) - N_PRO){1'b0}}, pro_chg};  // Top bits unused

   for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
      event_status_channel u_chan (
         .clk     (clk),
         .rrstz   (rrstz),
         .i_evt   (chan_evt[c]),
         .chan_if (chan_if[c])
      );
   end

   // ==================================================
   // Read side
   // ==================================================
   sfr_readback u_rd (
      .i_sfr_addr (i_sfr_addr),
      .rd_if      (chan_if),
      .i_txctl    (o_txctl),
      .i_gpf      (o_gpf),
      .i_ccctl    (o_ccctl),
      .i_cmp_opt  (o_cmp_opt),
      .i_pro_lvl  (pro_lvl),
      .o_sfr_rdat (o_sfr_rdat),
      .o_intr     (o_intr)
   );

endmodule

// ==== design/sfr_readback.sv ====
`timescale 1ns/1ps

module sfr_readback
   import sfr_map_pkg::*;
   import event_pkg::*;
(
   input  sfr_addr_t         i_sfr_addr,
   stat_chan_if.rd           rd_if [N_CHAN],
   input  sfr_data_t         i_txctl,
   input  sfr_data_t         i_gpf,
   input  sfr_data_t         i_ccctl,
   input  sfr_data_t         i_cmp_opt,
   input  pro_vec_t          i_pro_lvl,
   output sfr_data_t         o_sfr_rdat,
   output logic [N_CHAN-1:0] o_intr
);

   sfr_data_t sta_v [N_CHAN];
   sfr_data_t msk_v [N_CHAN];

   // Flatten the interface array so the mux can loop over it
   for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
      assign sta_v[c]  = rd_if[c].sta;
      assign msk_v[c]  = rd_if[c].msk;
      assign o_intr[c] = rd_if[c].irq;
   end

   // ==================================================
   // Read data mux
   // ==================================================
   always_comb begin
      o_sfr_rdat = SFR_UNUSED;
      case (i_sfr_addr)
         ADDR_TXCTL:  o_sfr_rdat = i_txctl;
         ADDR_GPF:    o_sfr_rdat = i_gpf;
         ADDR_CCCTL:  o_sfr_rdat = i_ccctl;
         ADDR_CMPOPT: o_sfr_rdat = i_cmp_opt;
         ADDR_PROLVL: o_sfr_rdat = {{($bits(sfr_data_t) - N_PRO){1'b0}}, i_pro_lvl};
         default:     ;
      endcase
      for (int c = 0; c < N_CHAN; c++) begin
         if (i_sfr_addr == STA_ADDR[c])
            o_sfr_rdat = sta_v[c];
         if (i_sfr_addr == MSK_ADDR[c])
            o_sfr_rdat = msk_v[c];
      end
   end

endmodule

// ==== design/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs
   import sfr_map_pkg::*;
(
   input  logic      clk,
   input  logic      rrstz,
   input  ctrl_we_t  i_we,
   input  sfr_data_t i_wdat,
   output sfr_data_t o_txctl,
   output sfr_data_t o_gpf,
   output sfr_data_t o_ccctl,
   output sfr_data_t o_cmp_opt
);

   // Reset values in strobe bit order
   localparam sfr_data_t CTRL_RST [N_CTRL] = '{RST_TXCTL, RST_GPF, RST_CCCTL, RST_CMPOPT};

   sfr_data_t ctrl_q [N_CTRL];

   for (genvar r = 0; r < N_CTRL; r++) begin : g_reg
      always_ff @(posedge clk or negedge rrstz) begin
         if (!rrstz) begin
            ctrl_q[r] <= CTRL_RST[r];
         end else if (i_we[r]) begin
            ctrl_q[r] <= i_wdat;
         end
      end
   end

   // Outputs double as the read-back path
   assign o_txctl   = ctrl_q[CTRL_TXCTL];
   assign o_gpf     = ctrl_q[CTRL_GPF];
   assign o_ccctl   = ctrl_q[CTRL_CCCTL];
   assign o_cmp_opt = ctrl_q[CTRL_CMPOPT];

endmodule

// ==== design/event_conditioner.sv ====
`timescale 1ns/1ps

module event_conditioner
   import sfr_map_pkg::*;
   import event_pkg::*;
(
   input  logic      clk,
   input  logic      rrstz,
   input  sfr_data_t i_p0,
   input  pro_vec_t  i_srci,
   output evt_vec_t  o_p0_chg,
   output pro_vec_t  o_pro_lvl,
   output pro_vec_t  o_pro_chg
);

   // ==================================================
   // Port-0 change detect
   // ==================================================
   sfr_data_t p0_prev;

   always_ff @(posedge clk or negedge rrstz) begin
      if (!rrstz) begin
         p0_prev <= '0;
      end else begin
         p0_prev <= i_p0;
      end
   end

   assign o_p0_chg = p0_prev ^ i_p0;  // Any edge, either direction

   // ==================================================
   // Protection input sync and debounce
   // ==================================================
   for (genvar i = 0; i < N_PRO; i++) begin : g_pro
      logic [SYNC_STAGES-1:0] sync_q;
      db_cnt_t                cnt_q;  // Consecutive differing samples
      logic                   lvl_q;
      logic                   smp;
      logic                   chg;

      assign smp = sync_q[SYNC_STAGES-1];
      // Third differing sample flips the level in this cycle
      assign chg = (smp != lvl_q) && (cnt_q == db_cnt_t'(DB_COUNT - 1));

      always_ff @(posedge clk or negedge rrstz) begin
         if (!rrstz) begin
            sync_q <= '0;
            cnt_q  <= '0;
            lvl_q  <= 1'b0;
         end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], i_srci[i]};
            if (smp == lvl_q) begin
               cnt_q <= '0;  // Glitch gone, start over
            end else if (chg) begin
               lvl_q <= smp;
               cnt_q <= '0;
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end

      assign o_pro_lvl[i] = lvl_q;
      assign o_pro_chg[i] = chg;
   end

endmodule

// ==== design/event_status_channel.sv ====
`timescale 1ns/1ps

module event_status_channel
   import sfr_map_pkg::*;
   import event_pkg::*;
(
   input  logic      clk,
   input  logic      rrstz,
   input  evt_vec_t  i_evt,
   stat_chan_if.chan chan_if
);

   sfr_data_t sta_q;
   sfr_data_t msk_q;
   sfr_data_t clr;

   assign clr = chan_if.wr_sta ? chan_if.wdat : '0;  // Write 1 to clear

   always_ff @(posedge clk or negedge rrstz) begin
      if (!rrstz) begin
         sta_q <= '0;
         msk_q <= '0;
      end else begin
         // Event set is ORed in last so it beats a clear in the same cycle
         sta_q <= (sta_q & ~clr) | i_evt;
         if (chan_if.wr_msk) begin
            msk_q <= chan_if.wdat;
         end
      end
   end

   assign chan_if.sta = sta_q;
   assign chan_if.msk = msk_q;
   assign chan_if.irq = |(sta_q & msk_q);  // Any unmasked pending bit

endmodule

// ==== design/sfr_decoder.sv ====
`timescale 1ns/1ps

module sfr_decoder
   import sfr_map_pkg::*;
   import event_pkg::*;
(
   input  logic      i_sfr_w,
   input  sfr_addr_t i_sfr_addr,
   input  sfr_data_t i_sfr_wdat,
   output ctrl_we_t  o_ctrl_we,
   output sfr_data_t o_wdat,
   stat_chan_if.dec  chan_if [N_CHAN]
);

   // ==================================================
   // Control register strobes
   // ==================================================
   assign o_ctrl_we[CTRL_TXCTL]  = i_sfr_w && (i_sfr_addr == ADDR_TXCTL);
   assign o_ctrl_we[CTRL_GPF]    = i_sfr_w && (i_sfr_addr == ADDR_GPF);
   assign o_ctrl_we[CTRL_CCCTL]  = i_sfr_w && (i_sfr_addr == ADDR_CCCTL);
   assign o_ctrl_we[CTRL_CMPOPT] = i_sfr_w && (i_sfr_addr == ADDR_CMPOPT);

   assign o_wdat = i_sfr_wdat;  // Shared by all control regs

   // ==================================================
   // Status channel strobes
   // ==================================================
   // Each channel owns one status and one mask address
   for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
      assign chan_if[c].wr_sta = i_sfr_w && (i_sfr_addr == STA_ADDR[c]);
      assign chan_if[c].wr_msk = i_sfr_w && (i_sfr_addr == MSK_ADDR[c]);
      assign chan_if[c].wdat   = i_sfr_wdat;
   end

endmodule

// ==== design/stat_chan_if.sv ====
`timescale 1ns/1ps

interface stat_chan_if
   import sfr_map_pkg::*;
();

   logic      wr_sta;  // Write-1-to-clear strobe
   logic      wr_msk;  // Mask write strobe
   sfr_data_t wdat;
   sfr_data_t sta;
   sfr_data_t msk;
   logic      irq;

   modport dec (
      output wr_sta, wr_msk, wdat
   );

   modport chan (
      input  wr_sta, wr_msk, wdat,
      output sta, msk, irq
   );

   modport rd (
      input sta, msk, irq
   );

endinterface

// ==== design/sfr_map_pkg.sv ====
package sfr_map_pkg;

   import event_pkg::*;

   // ==================================================
   // Bus types
   // ==================================================
   typedef logic [7:0] sfr_data_t;
   typedef logic [7:0] sfr_addr_t;

   // Unmapped locations read all ones
   localparam sfr_data_t SFR_UNUSED = 8'hFF;

   // ==================================================
   // Register map
   // ==================================================
   localparam sfr_addr_t ADDR_TXCTL  = 8'hB0;
   localparam sfr_addr_t ADDR_GPF    = 8'hBF;
   localparam sfr_addr_t ADDR_CCCTL  = 8'hE7;
   localparam sfr_addr_t ADDR_CMPOPT = 8'hE8;
   localparam sfr_addr_t ADDR_PROLVL = 8'hAD;  // Read only

   // Indexed by channel: RX, TX, I2C, P0, PRO
   localparam sfr_addr_t STA_ADDR [N_CHAN] = '{8'hB3, 8'hB4, 8'hCC, 8'hDF, 8'hAE};
   localparam sfr_addr_t MSK_ADDR [N_CHAN] = '{8'hB5, 8'hB6, 8'hCB, 8'hDE, 8'hAF};

   // ==================================================
   // Control registers
   // ==================================================
   localparam int N_CTRL = 4;

   // Bit positions in the write strobe vector
   localparam int CTRL_TXCTL  = 0;
   localparam int CTRL_GPF    = 1;
   localparam int CTRL_CCCTL  = 2;
   localparam int CTRL_CMPOPT = 3;

   typedef logic [N_CTRL-1:0] ctrl_we_t;  // One-hot

   localparam sfr_data_t RST_TXCTL  = 8'h00;
   localparam sfr_data_t RST_GPF    = 8'h00;
   localparam sfr_data_t RST_CCCTL  = 8'h00;
   localparam sfr_data_t RST_CMPOPT = 8'h00;

endpackage

// ==== design/event_pkg.sv ====
package event_pkg;

   // ==================================================
   // Interrupt status channels
   // ==================================================
   localparam int N_CHAN = 5;

   // Channel order, also the o_intr bit order
   localparam int CH_RX  = 0;  // Receiver
   localparam int CH_TX  = 1;  // Transmitter
   localparam int CH_I2C = 2;  // I2C slave
   localparam int CH_P0  = 3;  // Port-0 change
   localparam int CH_PRO = 4;  // Protection

   // Set inputs of one status byte
   typedef logic [7:0] evt_vec_t;

   // ==================================================
   // Protection inputs
   // ==================================================
   localparam int N_PRO = 6;

   typedef logic [N_PRO-1:0] pro_vec_t;

   // Flops between the pad and the debouncer
   localparam int SYNC_STAGES = 2;

   // Differing samples needed to flip the level
   localparam int DB_COUNT = 3;

   // Must hold DB_COUNT-1
   typedef logic [1:0] db_cnt_t;

endpackage
